//--- source/lsab_pkg.sv
package lsab_pkg;

  localparam int NUM_FIFOS = 4;
  localparam int PTR_W     = 6; // 64 words per FIFO region
  localparam int SEL_W     = 2;
  localparam int DATA_W    = 32;

  localparam int MAX_LEN             = 63; // one slot kept free
  localparam int BFULL_LEVEL_DEFAULT = 55;

  typedef logic [SEL_W-1:0] fifo_sel_t;

  typedef logic [PTR_W-1:0] ptr_t; // pointer or length

  // fifo number on top, pointer below
  typedef logic [SEL_W+PTR_W-1:0] mem_addr_t;

  typedef logic [DATA_W-1:0] word_t;

endpackage

//--- source/lsab_mem_if.sv
`timescale 1ns/1ps

interface lsab_mem_if;
  import lsab_pkg::*;

  mem_addr_t waddr;
  logic      we;
  word_t     wdata;
  mem_addr_t raddr;
  logic      re;
  word_t     rdata; // registered in the memory
  fifo_sel_t rsel;  // fifo of the current read

  modport mux (
    output waddr, we, raddr, re, rsel
  );

  modport mem (
    input  waddr, we, wdata, raddr, re,
    output rdata
  );

  modport out (
    input re, rsel, rdata
  );

endinterface

//--- source/lsab_fifo_ctrl.sv
`timescale 1ns/1ps

module lsab_fifo_ctrl #(
  parameter int BFULL_LEVEL = lsab_pkg::BFULL_LEVEL_DEFAULT
) (
  input  logic           CLK,
  input  logic           RST,
  input  logic           wr_req,
  input  logic           rd_req,
  output logic           wr_ok,
  output logic           rd_ok,
  output lsab_pkg::ptr_t wr_ptr,
  output lsab_pkg::ptr_t rd_ptr,
  output logic           bfull
);
  import lsab_pkg::*;

  ptr_t len;
  ptr_t len_next;
  logic empty;
  logic full;

  // requests against a full or empty fifo are dropped
  assign wr_ok = wr_req && !full;
  assign rd_ok = rd_req && !empty;

  always_comb begin
    case ({rd_ok, wr_ok})
      2'b10: begin
        len_next = len - 1'b1;
      end
      2'b01: begin
        len_next = len + 1'b1;
      end
      default: begin
        len_next = len; // idle, or read and write cancel out
      end
    endcase
  end

  // flags come from the next length, so they are valid right after the edge
  always_ff @(posedge CLK) begin
    if (!RST) begin
      len    <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      empty  <= 1'b1;
      full   <= 1'b0;
      bfull  <= 1'b0;
    end else begin
      len   <= len_next;
      empty <= (len_next == '0);
      full  <= (len_next == ptr_t'(MAX_LEN));
      bfull <= (len_next >= ptr_t'(BFULL_LEVEL)); // near-full threshold

      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1; // wraps inside the 64-word region
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

//--- source/lsab_port_mux.sv
`timescale 1ns/1ps

module lsab_port_mux (
  input  logic                          write,
  input  lsab_pkg::fifo_sel_t           write_fifo,
  input  logic [lsab_pkg::NUM_FIFOS-1:0] read_req,
  input  lsab_pkg::fifo_sel_t           read_fifo,
  input  logic [lsab_pkg::NUM_FIFOS-1:0] wr_ok,
  input  logic [lsab_pkg::NUM_FIFOS-1:0] rd_ok,
  input  lsab_pkg::ptr_t                wr_ptr [lsab_pkg::NUM_FIFOS],
  input  lsab_pkg::ptr_t                rd_ptr [lsab_pkg::NUM_FIFOS],
  output logic [lsab_pkg::NUM_FIFOS-1:0] wr_req,
  output logic [lsab_pkg::NUM_FIFOS-1:0] rd_req,
  lsab_mem_if.mux                       mem
);
  import lsab_pkg::*;

  // one request per fifo
  always_comb begin
    for (int i = 0; i < NUM_FIFOS; i++) begin
      wr_req[i] = write && (write_fifo == fifo_sel_t'(i));
      rd_req[i] = read_req[i] && (read_fifo == fifo_sel_t'(i)); // other bits ignored
    end
  end

  // write side of the shared port
  assign mem.we    = wr_ok[write_fifo];
  assign mem.waddr = {write_fifo, wr_ptr[write_fifo]};

  // read side with the fifo number for the output stage
  assign mem.re    = rd_ok[read_fifo];
  assign mem.raddr = {read_fifo, rd_ptr[read_fifo]};
  assign mem.rsel  = read_fifo;

endmodule

//--- source/lsab_sram.sv
`timescale 1ns/1ps

module lsab_sram (
  input logic     CLK,
  lsab_mem_if.mem mem
);
  import lsab_pkg::*;

  localparam int DEPTH = 1 << $bits(mem_addr_t); // 4 regions of 64 words

  word_t ram [DEPTH];

  always_ff @(posedge CLK) begin
    if (mem.we) begin
      ram[mem.waddr] <= mem.wdata;
    end
  end

  // rdata holds unless re is high
  always_ff @(posedge CLK) begin
    if (mem.re) begin
      mem.rdata <= ram[mem.raddr];
    end
  end

endmodule

//--- source/lsab_read_out.sv
`timescale 1ns/1ps

module lsab_read_out (
  input  logic           CLK,
  input  logic           RST,
  lsab_mem_if.out        mem,
  output lsab_pkg::word_t out_0,
  output lsab_pkg::word_t out_1,
  output lsab_pkg::word_t out_2,
  output lsab_pkg::word_t out_3
);
  import lsab_pkg::*;

  logic      re_d;   // read issued last cycle
  fifo_sel_t rsel_d; // and its fifo

  always_ff @(posedge CLK) begin
    if (!RST) begin
      re_d   <= 1'b0;
      rsel_d <= '0;
      out_0  <= '0;
      out_1  <= '0;
      out_2  <= '0;
      out_3  <= '0;
    end else begin
      re_d   <= mem.re;
      rsel_d <= mem.rsel;
      if (re_d) begin
        case (rsel_d)
          2'd0:    out_0 <= mem.rdata;
          2'd1:    out_1 <= mem.rdata;
          2'd2:    out_2 <= mem.rdata;
          default: out_3 <= mem.rdata;
        endcase
      end
    end
  end

endmodule

//--- source/lsab_top.sv
`timescale 1ns/1ps

module lsab_top #(
  parameter int BFULL_LEVEL = lsab_pkg::BFULL_LEVEL_DEFAULT
) (
  input  logic                           CLK,
  input  logic                           RST,
  input  logic                           write,
  input  lsab_pkg::fifo_sel_t            write_fifo,
  input  lsab_pkg::word_t                wr_data,
  input  logic [lsab_pkg::NUM_FIFOS-1:0] read_req,
  input  lsab_pkg::fifo_sel_t            read_fifo,
  output lsab_pkg::word_t                out_0,
  output lsab_pkg::word_t                out_1,
  output lsab_pkg::word_t                out_2,
  output lsab_pkg::word_t                out_3,
  output logic [lsab_pkg::NUM_FIFOS-1:0] bfull
);
  import lsab_pkg::*;

  logic [NUM_FIFOS-1:0] wr_req;
  logic [NUM_FIFOS-1:0] rd_req;
  logic [NUM_FIFOS-1:0] wr_ok;
  logic [NUM_FIFOS-1:0] rd_ok;
  ptr_t                 wr_ptr [NUM_FIFOS];
  ptr_t                 rd_ptr [NUM_FIFOS];

  lsab_mem_if mem_if ();

  assign mem_if.wdata = wr_data; // single writer

  for (genvar i = 0; i < NUM_FIFOS; i++) begin : g_fifo
    lsab_fifo_ctrl #(
      .BFULL_LEVEL(BFULL_LEVEL)
    ) u_ctrl (
      .CLK   (CLK),
      .RST   (RST),
      .wr_req(wr_req[i]),
      .rd_req(rd_req[i]),
      .wr_ok (wr_ok[i]),
      .rd_ok (rd_ok[i]),
      .wr_ptr(wr_ptr[i]),
      .rd_ptr(rd_ptr[i]),
      .bfull (bfull[i])
    );
  end

  lsab_port_mux u_mux (
    .write     (write),
    .write_fifo(write_fifo),
    .read_req  (read_req),
    .read_fifo (read_fifo),
    .wr_ok     (wr_ok),
    .rd_ok     (rd_ok),
    .wr_ptr    (wr_ptr),
    .rd_ptr    (rd_ptr),
    .wr_req    (wr_req),
    .rd_req    (rd_req),
    .mem       (mem_if.mux)
  );

  lsab_sram u_sram (
    .CLK(CLK),
    .mem(mem_if.mem)
  );

  // two edges from read strobe to out_n
  lsab_read_out u_out (
    .CLK  (CLK),
    .RST  (RST),
    .mem  (mem_if.out),
    .out_0(out_0),
    .out_1(out_1),
    .out_2(out_2),
    .out_3(out_3)
  );

endmodule

//--- test/tb_lsab.sv
`timescale 1ns/1ps

module tb_lsab;
  import lsab_pkg::*;

  localparam int BFULL_LEVEL = 55;
  localparam int FIFO_CAP    = 63;
  localparam int DRAIN_LIMIT = 200; // cycles per fifo

  logic                 CLK;
  logic                 RST;
  logic                 write;
  fifo_sel_t            write_fifo;
  word_t                wr_data;
  logic [NUM_FIFOS-1:0] read_req;
  fifo_sel_t            read_fifo;
  word_t                out_0;
  word_t                out_1;
  word_t                out_2;
  word_t                out_3;
  logic [NUM_FIFOS-1:0] bfull;

  word_t                model_q [NUM_FIFOS][$];
  word_t                exp_out [NUM_FIFOS];
  logic [NUM_FIFOS-1:0] exp_bfull;
  logic                 pend_hit;  // read accepted at the last edge
  fifo_sel_t            pend_fifo;
  word_t                pend_word;
  logic                 check_en;
  logic [31:0]          seed;
  string                test_name;

  lsab_top #(
    .BFULL_LEVEL(BFULL_LEVEL)
  ) DUT (
    .CLK       (CLK),
    .RST       (RST),
    .write     (write),
    .write_fifo(write_fifo),
    .wr_data   (wr_data),
    .read_req  (read_req),
    .read_fifo (read_fifo),
    .out_0     (out_0),
    .out_1     (out_1),
    .out_2     (out_2),
    .out_3     (out_3),
    .bfull     (bfull)
  );

  always #5 CLK = ~CLK;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // distinct word per fifo and index
  function automatic word_t word_for(input fifo_sel_t f, input int n);
    return {8'hC0 | 8'(f), 24'(n * 7 + 1)};
  endfunction

  function automatic word_t out_of(input fifo_sel_t f);
    case (f)
      2'd0:    return out_0;
      2'd1:    return out_1;
      2'd2:    return out_2;
      default: return out_3;
    endcase
  endfunction

  // one cycle of strobes against the queue model
  function automatic void model_step(
    input  logic                 wr,
    input  fifo_sel_t            wf,
    input  word_t                wd,
    input  logic [NUM_FIFOS-1:0] rr,
    input  fifo_sel_t            rf,
    output logic                 rd_hit,
    output word_t                rd_word,
    output logic [NUM_FIFOS-1:0] bf
  );
    logic wr_hit;
    wr_hit  = wr && (model_q[wf].size() < FIFO_CAP); // full test before the read
    rd_hit  = rr[rf] && (model_q[rf].size() > 0);
    rd_word = '0;
    if (rd_hit) begin
      rd_word = model_q[rf].pop_front();
    end
    if (wr_hit) begin
      model_q[wf].push_back(wd);
    end
    for (int i = 0; i < NUM_FIFOS; i++) begin
      bf[i] = model_q[i].size() >= BFULL_LEVEL;
    end
  endfunction

  always @(posedge CLK) begin
    if (!RST) begin
      for (int i = 0; i < NUM_FIFOS; i++) begin
        model_q[i].delete();
        exp_out[i] = '0;
      end
      pend_hit  = 1'b0;
      exp_bfull = '0;
    end else begin
      if (pend_hit) begin
        exp_out[pend_fifo] = pend_word; // second edge after the strobe
      end
      model_step(write, write_fifo, wr_data, read_req, read_fifo,
                 pend_hit, pend_word, exp_bfull);
      pend_fifo = read_fifo;
    end
  end

  task automatic stop_with_failure();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic abort_run(input string why);
    $display("%s: %s", test_name, why);
    stop_with_failure();
  endtask

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      $display("[FAIL] %s %s expected %h actual %h", test_name, what, exp, act);
      stop_with_failure();
    end
  endtask

  // mid-cycle check of every output against the model
  always @(negedge CLK) begin
    if (check_en) begin
      check_value("out_0", exp_out[0], out_0);
      check_value("out_1", exp_out[1], out_1);
      check_value("out_2", exp_out[2], out_2);
      check_value("out_3", exp_out[3], out_3);
      check_value("bfull", 32'(exp_bfull), 32'(bfull));
    end
  end

  task automatic drive(input logic wr, input fifo_sel_t wf, input word_t wd,
                       input logic [NUM_FIFOS-1:0] rr, input fifo_sel_t rf);
    @(posedge CLK);
    #1;
    write      = wr;
    write_fifo = wf;
    wr_data    = wd;
    read_req   = rr;
    read_fifo  = rf;
  endtask

  task automatic idle();
    drive(1'b0, 2'd0, '0, 4'd0, 2'd0);
  endtask

  // strobe and look two edges later
  task automatic read_check(input fifo_sel_t f, input word_t exp);
    drive(1'b0, 2'd0, '0, 4'b0001 << f, f);
    idle();
    @(posedge CLK);
    #1;
    check_value($sformatf("out_%0d", f), exp, out_of(f));
  endtask

  task automatic drain_fifo(input fifo_sel_t f, input int limit);
    int n;
    n = 0;
    while (model_q[f].size() > 0 && n < limit) begin
      drive(1'b0, 2'd0, '0, 4'b0001 << f, f);
      n++;
    end
    if (model_q[f].size() > 0) begin
      abort_run($sformatf("fifo %0d did not drain within %0d cycles", f, limit));
    end else begin
      idle();
    end
  endtask

  task automatic random_traffic(input int cycles, input int write_thr);
    logic [31:0]          r;
    word_t                d;
    logic                 wr;
    fifo_sel_t            wf;
    fifo_sel_t            rf;
    logic [NUM_FIFOS-1:0] rr;
    for (int c = 0; c < cycles; c++) begin
      seed = lcg_next(seed);
      r    = seed;
      seed = lcg_next(seed);
      d    = seed;
      wr   = int'(r[31:24]) < write_thr; // upper bits only
      wf   = r[23:22];
      rf   = r[21:20];
      rr   = r[19:16];
      if (r[15:13] == 3'd0) begin
        rf     = wf; // read and write on one fifo
        rr[wf] = 1'b1;
      end
      drive(wr, wf, d, rr, rf);
    end
  endtask

  initial begin
    CLK        = 1'b0;
    RST        = 1'b0;
    write      = 1'b0;
    write_fifo = 2'd0;
    wr_data    = '0;
    read_req   = '0;
    read_fifo  = 2'd0;
    check_en   = 1'b0;
    seed       = 32'h5111_2df7;

    test_name = "reset";
    repeat (3) @(posedge CLK);
    #1;
    RST      = 1'b1;
    check_en = 1'b1;
    check_value("bfull", 32'h0, 32'(bfull));
    for (int f = 0; f < NUM_FIFOS; f++) begin
      check_value($sformatf("out_%0d", f), 32'h0, out_of(fifo_sel_t'(f)));
    end

    test_name = "ordering";
    for (int n = 0; n < 12; n++) begin
      drive(1'b1, fifo_sel_t'(n % 4), word_for(fifo_sel_t'(n % 4), n / 4), 4'd0, 2'd0);
    end
    idle();
    for (int n = 0; n < 3; n++) begin
      for (int f = 0; f < NUM_FIFOS; f++) begin
        read_check(fifo_sel_t'(f), word_for(fifo_sel_t'(f), n));
      end
    end

    test_name = "empty and mismatched reads";
    drive(1'b1, 2'd1, word_for(2'd1, 20), 4'd0, 2'd0);
    drive(1'b0, 2'd0, '0, 4'b0001, 2'd0); // fifo 0 is empty
    drive(1'b0, 2'd0, '0, 4'b0010, 2'd2); // fifo 1 bit set while fifo 2 is selected
    drive(1'b0, 2'd0, '0, 4'b0100, 2'd1); // fifo 1 selected with its bit low
    idle();
    @(posedge CLK);
    #1;
    for (int f = 0; f < NUM_FIFOS; f++) begin
      check_value($sformatf("out_%0d", f), word_for(fifo_sel_t'(f), 2),
                  out_of(fifo_sel_t'(f)));
    end
    read_check(2'd1, word_for(2'd1, 20));

    test_name = "full fifo";
    for (int n = 0; n < 70; n++) begin
      drive(1'b1, 2'd3, word_for(2'd3, n), 4'd0, 2'd0);
    end
    idle();
    check_value("bfull", 32'h8, 32'(bfull));
    for (int n = 0; n < FIFO_CAP; n++) begin
      read_check(2'd3, word_for(2'd3, n));
    end
    read_check(2'd3, word_for(2'd3, FIFO_CAP - 1)); // nothing left
    check_value("bfull", 32'h0, 32'(bfull));

    test_name = "near-full flag";
    for (int n = 0; n < BFULL_LEVEL - 1; n++) begin
      drive(1'b1, 2'd2, word_for(2'd2, n), 4'd0, 2'd0);
    end
    idle();
    check_value("bfull", 32'h0, 32'(bfull));
    drive(1'b1, 2'd2, word_for(2'd2, BFULL_LEVEL - 1), 4'd0, 2'd0);
    idle();
    check_value("bfull", 32'h4, 32'(bfull));
    drive(1'b0, 2'd0, '0, 4'b0100, 2'd2);
    idle();
    check_value("bfull", 32'h0, 32'(bfull));
    drain_fifo(2'd2, DRAIN_LIMIT);

    test_name = "random traffic";
    random_traffic(1500, 200); // fills toward full
    random_traffic(1500, 40);  // mostly reads
    for (int f = 0; f < NUM_FIFOS; f++) begin
      drain_fifo(fifo_sel_t'(f), DRAIN_LIMIT);
    end
    repeat (2) @(posedge CLK); // last read reaches its output
    #1;

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- flist.f
source/lsab_pkg.sv
source/lsab_mem_if.sv
source/lsab_fifo_ctrl.sv
source/lsab_port_mux.sv
source/lsab_sram.sv
source/lsab_read_out.sv
source/lsab_top.sv
test/tb_lsab.sv

//--- Makefile
VERILATOR ?= verilator
FLIST     ?= flist.f
TB_TOP    ?= tb_lsab
RTL_TOP   ?= lsab_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --timing --assert
LINTFLAGS ?= --lint-only -Wall
RTL_SRCS  ?= $(filter source/%.sv,$(shell cat $(FLIST)))

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

sim: build
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then echo "simulation passed"; \
	else echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
